// File: list.f
+incdir+logic
logic/conv_pkg.sv
logic/sa_ctrl.sv
logic/mac_array.sv
logic/requant.sv
logic/conv_tail.sv
test/clk_gen.sv
test/conv_tail_chk.sv
test/conv_tail_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass line"
	@echo "  clean  remove the build directory and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module conv_tail_tb \
		-f list.f --Mdir obj_dir -o conv_tail_sim
	./obj_dir/conv_tail_sim +verilator+error+limit+1000 | tee sim.log
	@grep -qF '*** TEST PASSED ***' sim.log || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: test/conv_tail_tb.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_tail_tb;

    import conv_pkg::*;

    localparam int LATENCY      = 4;  // edges from last beat drive to out_valid seen
    localparam int OUT_MAX      = 2 ** (`OUT_W - 1) - 1;
    localparam int OUT_MIN      = -(2 ** (`OUT_W - 1));
    localparam int RAND_BATCHES = 6;
    localparam int BATCH_GROUPS = 8;
    localparam int MAX_LEN      = 6;
    localparam int MAX_GAP      = 2;
    localparam int DRAIN        = 12; // worst case flush plus quiet cycles
    localparam int FIXED_BEATS  = 3 + 5 + 1 + 10 + 3 + 11 + 3;
    localparam int WATCH_CYCLES = FIXED_BEATS + 6 * DRAIN + 200
        + RAND_BATCHES * (BATCH_GROUPS * (MAX_LEN + 1) * (MAX_GAP + 1) + DRAIN);

    logic              clk;
    logic              gen_reset;
    logic              tb_reset;
    logic              reset;
    logic              mode;
    logic [`LEN_W-1:0] acc_len;
    logic              in_valid;
    pix_vec_t          pix;
    weight_word_u      wgt;
    quant_cfg_t        cfg;
    logic              out_valid;
    out_vec_t          out_pix;

    integer seed     = 32'hf0f80386;
    int     edge_cnt = 0;
    int     checks   = 0;
    int     errors   = 0;
    int     n_tests  = 0;
    int     t_checks = 0;
    int     t_errs   = 0;
    string  cur_test = "none";
    int     b2b_lens [8] = '{1, 1, 1, 2, 1, 2, 1, 1};

    out_vec_t     exp_q[$];  // expected results, issue order
    int           edge_q[$]; // edge count at each last beat
    pix_vec_t     beat_pix[$];
    weight_word_u beat_wgt[$];

    assign reset = gen_reset | tb_reset;

    clk_gen u_clk (.clk(clk), .reset(gen_reset));

    conv_tail dut0 (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .acc_len   (acc_len),
        .in_valid  (in_valid),
        .pix       (pix),
        .wgt       (wgt),
        .cfg       (cfg),
        .out_valid (out_valid),
        .out_pix   (out_pix)
    );

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    ////////////////////////////// reference model

    function automatic out_vec_t ref_group(input logic m, input pix_vec_t pq[$],
                                           input weight_word_u wq[$], input quant_cfg_t qc);
        out_vec_t    res;
        logic [15:0] raw;
        logic [7:0]  wbyte;
        longint      acc;
        longint      p;
        longint      q;
        int          w;
        for (int c = 0; c < `NUM_CH; c++) begin
            for (int l = 0; l < `NUM_PIX; l++) begin
                acc = 0;
                for (int b = 0; b < pq.size(); b++) begin
                    raw   = wq[b];
                    wbyte = raw[8*c +: 8]; // byte c belongs to channel c
                    if (m) begin
                        w = wbyte[l] ? -1 : 1;
                    end else begin
                        w = $signed(wbyte);
                    end
                    acc += longint'(pq[b][l]) * w;
                end
                p = (acc + longint'($signed(qc[c].bias))) * longint'(qc[c].tail);
                if (qc[c].rank == 0) begin
                    q = p;
                end else begin
                    q = (p + (64'sd1 <<< (qc[c].rank - 1))) >>> qc[c].rank;
                end
                if (q > OUT_MAX) begin
                    q = OUT_MAX;
                end else if (q < OUT_MIN) begin
                    q = OUT_MIN;
                end
                res[c][l] = out_t'(q);
            end
        end
        return res;
    endfunction

    ////////////////////////////// checks

    task automatic check_out(input string name, input out_vec_t exp, input out_vec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: out_pix expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input integer exp, input integer act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: latency expected %0d actual %0d", name, exp, act);
        end
    endtask

    // outputs only move on rising edges, read them on the falling one
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR %s: out_valid seen with no group pending", cur_test);
            end else begin
                check_out(cur_test, exp_q.pop_front(), out_pix);
                check_latency(cur_test, LATENCY, edge_cnt - edge_q.pop_front());
            end
        end
    end

    ////////////////////////////// stimulus

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // in_valid stays up after the last beat so groups can run back to back
    task automatic send_group(input logic m, input int gap_max);
        int len;
        int gap;
        len = beat_pix.size();
        for (int b = 0; b < len; b++) begin
            @(negedge clk);
            mode     = m;
            acc_len  = len[`LEN_W-1:0];
            in_valid = 1'b1;
            pix      = beat_pix[b];
            wgt      = beat_wgt[b];
            if (b == len - 1) begin
                exp_q.push_back(ref_group(m, beat_pix, beat_wgt, cfg));
                edge_q.push_back(edge_cnt);
            end else if (gap_max > 0) begin
                gap = $unsigned($random(seed)) % (gap_max + 1);
                idle(gap);
            end
        end
    endtask

    task automatic fill_random(input int len);
        beat_pix.delete();
        beat_wgt.delete();
        repeat (len) begin
            beat_pix.push_back(pix_vec_t'($random(seed)));
            beat_wgt.push_back(weight_word_u'(16'($random(seed))));
        end
    endtask

    task automatic set_cfg(input int c, input int bias, input int tail, input int rank);
        cfg[c].bias = bias;
        cfg[c].tail = tail;
        cfg[c].rank = rank;
    endtask

    task automatic random_cfg();
        for (int c = 0; c < `NUM_CH; c++) begin
            set_cfg(c, $random(seed), $random(seed), 8 + $unsigned($random(seed)) % 24);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        t_checks = checks;
        t_errs   = errors;
    endtask

    // idle until every pending result is compared, then watch a few quiet cycles
    task automatic end_test();
        idle(1);
        while (exp_q.size() != 0) begin
            idle(1);
        end
        idle(6);
        n_tests++;
        $display("test %s: %0d checks, %0d errors", cur_test, checks - t_checks,
                 errors - t_errs);
    endtask

    ////////////////////////////// test sequence

    initial begin
        int len;
        mode     = 1'b0;
        acc_len  = 1;
        in_valid = 1'b0;
        pix      = '0;
        wgt      = '0;
        cfg      = '0;
        tb_reset = 1'b0;
        wait (gen_reset === 1'b0);
        idle(2);

        start_test("int8_fixed");
        set_cfg(0, 10, 1, 0);
        set_cfg(1, -20, 1, 0);
        // lane 3 of the first beat is large enough to clip both channels
        beat_pix = '{32'h60030201, 32'h08070605, 32'h01000100};
        beat_wgt = '{16'hfe03, 16'h04ff, 16'hfb07}; // {ch1, ch0} signed bytes
        send_group(1'b0, 1);
        end_test();

        start_test("binary");
        set_cfg(0, 0, 1, 0);
        set_cfg(1, 5, 1, 0);
        beat_pix = '{32'h05040302, 32'h01020304, 32'h0a0b0c0d, 32'h10111213, 32'h07070707};
        beat_wgt = '{16'h0a05, 16'h0c03, 16'h0f00, 16'h0609, 16'h050a};
        send_group(1'b1, 2);
        end_test();

        start_test("scaling");
        // tail/2^rank is 1.5, odd pixels land on exactly half, lane 3 clips
        set_cfg(0, 0, 16'hc000, 15);
        set_cfg(1, 0, 16'hc000, 15);
        beat_pix = '{32'hc8070301};
        beat_wgt = '{16'hff01};
        send_group(1'b0, 0);
        end_test();

        start_test("back_to_back");
        set_cfg(0, 3, 16'h0180, 9);
        set_cfg(1, -7, 16'h0180, 9);
        foreach (b2b_lens[i]) begin
            fill_random(b2b_lens[i]);
            send_group(1'($random(seed)), 0);
        end
        end_test();

        start_test("reset_mid_group");
        fill_random(3);
        // a finished one-beat group is still inside requant when reset hits
        for (int b = 0; b < 3; b++) begin
            @(negedge clk);
            mode     = 1'b0;
            acc_len  = (b == 0) ? 1 : 4;
            in_valid = 1'b1;
            pix      = beat_pix[b];
            wgt      = beat_wgt[b];
        end
        @(negedge clk);
        in_valid = 1'b0;
        tb_reset = 1'b1;
        idle(2);
        tb_reset = 1'b0;
        idle(8); // flushed and aborted groups must stay silent
        fill_random(3);
        send_group(1'b0, 0);
        end_test();

        start_test("random");
        for (int k = 0; k < RAND_BATCHES; k++) begin
            random_cfg(); // pipeline is empty here
            for (int g = 0; g < BATCH_GROUPS; g++) begin
                len = 1 + $unsigned($random(seed)) % MAX_LEN;
                fill_random(len);
                send_group(1'($random(seed)), MAX_GAP);
                idle($unsigned($random(seed)) % (MAX_GAP + 1));
            end
            idle(1);
            while (exp_q.size() != 0) begin
                idle(1);
            end
        end
        end_test();

        errors += dut0.chk0.assert_errs;
        $display("done: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCH_CYCLES * 8);
        $display("timeout: run did not finish within %0d cycles", WATCH_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: test/conv_tail_chk.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_tail_chk (
    input logic              clk,
    input logic              reset,
    input logic              in_valid,
    input logic [`LEN_W-1:0] acc_len,
    input logic              out_valid
);

    int assert_errs = 0; // failed assertion count

    ////////////////////////////// control
    // a reset cycle always leaves the output quiet
    reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            assert_errs++;
            $error("out_valid high in the cycle after reset");
        end

    len_nonzero: assert property (@(posedge clk) disable iff (reset) in_valid |-> acc_len != '0)
        else begin
            assert_errs++;
            $error("beat presented with acc_len of zero");
        end

    ////////////////////////////// output pulse
    // every result cycle traces back to its own beat four edges earlier
    out_pulse: assert property (@(posedge clk) disable iff (reset)
                                out_valid |-> $past(in_valid, 4))
        else begin
            assert_errs++;
            $error("out_valid without a beat four cycles earlier");
        end

endmodule

bind conv_tail conv_tail_chk chk0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .acc_len   (acc_len),
    .out_valid (out_valid)
);

// File: test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // high over the first two rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: logic/conv_tail.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_tail (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mode,
    input  logic [`LEN_W-1:0]      acc_len,
    input  logic                   in_valid,
    input  conv_pkg::pix_vec_t     pix,
    input  conv_pkg::weight_word_u wgt,
    input  conv_pkg::quant_cfg_t   cfg,
    output logic                   out_valid,
    output conv_pkg::out_vec_t     out_pix
);

    import conv_pkg::*;

    logic     acc_first;
    logic     acc_last;
    logic     sum_valid;
    acc_vec_t sums;

    sa_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .acc_len   (acc_len),
        .acc_first (acc_first),
        .acc_last  (acc_last)
    );

    mac_array u_mac (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .in_valid  (in_valid),
        .acc_first (acc_first),
        .acc_last  (acc_last),
        .pix       (pix),
        .wgt       (wgt),
        .sum_valid (sum_valid),
        .sums      (sums)
    );

    // 3 cycles from sums to out_pix
    requant u_quant (
        .clk       (clk),
        .reset     (reset),
        .sum_valid (sum_valid),
        .sums      (sums),
        .cfg       (cfg),
        .out_valid (out_valid),
        .out_pix   (out_pix)
    );

endmodule

// File: logic/requant.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module requant (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sum_valid,
    input  conv_pkg::acc_vec_t   sums,
    input  conv_pkg::quant_cfg_t cfg,
    output logic                 out_valid,
    output conv_pkg::out_vec_t   out_pix
);

    import conv_pkg::*;

    logic                      s1_valid;
    logic                      s2_valid;
    logic signed [`ACC_W:0]    s1_b [`NUM_CH][`NUM_PIX];  // acc + bias, one guard bit
    logic signed [`PROD_W-1:0] s2_p [`NUM_CH][`NUM_PIX];  // b * tail

    // rounding shift then saturate to OUT_W
    function automatic out_t round_clip(input logic signed [`PROD_W-1:0] p,
                                        input logic [`RANK_W-1:0]        rank);
        logic signed [`PROD_W:0] half;
        logic signed [`PROD_W:0] q;
        half = '0;
        if (rank != '0) begin
            half = 1'b1 << (rank - 1'b1); // half of one output step
        end
        q = (p + half) >>> rank;
        if (q > (2 ** (`OUT_W - 1) - 1)) begin
            return out_t'(2 ** (`OUT_W - 1) - 1);
        end else if (q < -(2 ** (`OUT_W - 1))) begin
            return out_t'(-(2 ** (`OUT_W - 1)));
        end
        return q[`OUT_W-1:0];
    endfunction

    ////////////////////////////// valid pipe

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= sum_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    ////////////////////////////// stage 1 bias add

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            for (int c = 0; c < `NUM_CH; c++) begin
                for (int l = 0; l < `NUM_PIX; l++) begin
                    s1_b[c][l] <= sums[c][l] + cfg[c].bias;
                end
            end
        end
    end

    ////////////////////////////// stage 2 scale multiply

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int c = 0; c < `NUM_CH; c++) begin
                for (int l = 0; l < `NUM_PIX; l++) begin
                    // tail is unsigned, zero extend before the signed multiply
                    s2_p[c][l] <= s1_b[c][l] * $signed({1'b0, cfg[c].tail});
                end
            end
        end
    end

    ////////////////////////////// stage 3 shift, round, clip

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            for (int c = 0; c < `NUM_CH; c++) begin
                for (int l = 0; l < `NUM_PIX; l++) begin
                    out_pix[c][l] <= round_clip(s2_p[c][l], cfg[c].rank);
                end
            end
        end
    end

endmodule

// File: logic/mac_array.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module mac_array (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mode,      // 0 int8, 1 binary
    input  logic                 in_valid,
    input  logic                 acc_first,
    input  logic                 acc_last,
    input  conv_pkg::pix_vec_t   pix,
    input  conv_pkg::weight_word_u wgt,
    output logic                 sum_valid,
    output conv_pkg::acc_vec_t   sums
);

    import conv_pkg::*;

    acc_vec_t prod;    // this beat's pixel * weight
    acc_vec_t acc;     // running totals
    acc_vec_t acc_nxt;

    ////////////////////////////// per-lane products

    genvar c, l;
    generate
        for (c = 0; c < `NUM_CH; c = c + 1) begin : g_ch
            for (l = 0; l < `NUM_PIX; l = l + 1) begin : g_lane
                logic signed [`PIX_W:0]   pix_s;
                logic signed [`PIX_W+8:0] mul_s;
                acc_t                     pix_ext;
                acc_t                     mul_ext;

                assign pix_s = {1'b0, pix[l]}; // pixels are unsigned
                assign mul_s = pix_s * wgt.int8[c];

                assign pix_ext = pix_s;
                assign mul_ext = mul_s; // sign extends to ACC_W

                // binary weight is just +-pixel, no multiplier needed
                assign prod[c][l] = mode ? (wgt.bin[c][l] ? -pix_ext : pix_ext)
                                         : mul_ext;

                // first beat loads instead of adding
                assign acc_nxt[c][l] = acc_first ? prod[c][l] : acc[c][l] + prod[c][l];
            end
        end
    endgenerate

    ////////////////////////////// accumulators

    always_ff @(posedge clk) begin
        if (in_valid) begin
            acc <= acc_nxt;
        end
        if (acc_last) begin
            sums <= acc_nxt; // frees acc for the next group right away
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= acc_last; // one cycle pulse
        end
    end

endmodule

// File: logic/sa_ctrl.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module sa_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [`LEN_W-1:0] acc_len,
    output logic             acc_first,
    output logic             acc_last
);

    logic [`LEN_W-1:0] beat_cnt; // beats already taken in this group
    logic [`LEN_W-1:0] grp_len;  // length latched at the first beat
    logic [`LEN_W-1:0] cur_len;
    logic [`LEN_W-1:0] cnt_nxt;

    ////////////////////////////// beat flags

    // first beat still sees acc_len directly, the latch is not loaded yet
    assign cur_len = (beat_cnt == '0) ? acc_len : grp_len;
    assign cnt_nxt = beat_cnt + 1'b1;

    assign acc_first = in_valid && (beat_cnt == '0);
    assign acc_last  = in_valid && (cnt_nxt == cur_len);

    ////////////////////////////// counter

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt <= '0;
        end else if (in_valid) begin
            if (acc_last) begin
                beat_cnt <= '0; // wrap, next beat opens a new group
            end else begin
                beat_cnt <= cnt_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grp_len <= '0;
        end else if (acc_first) begin
            grp_len <= acc_len;
        end
    end

endmodule

// File: logic/conv_pkg.sv
`include "conv_params.svh"

package conv_pkg;

    ////////////////////////////// pixel and weight beats

    typedef logic [`PIX_W-1:0] pix_t;
    typedef pix_t [`NUM_PIX-1:0] pix_vec_t; // all lanes of one beat

    typedef logic signed [7:0] wgt8_t;

    // one 16 bit word, two readings selected by mode
    typedef union packed {
        wgt8_t [`NUM_CH-1:0]      int8; // signed weight per channel
        logic [`NUM_CH-1:0][7:0] bin;  // per-lane sign bits, 1 means -1
    } weight_word_u;

    ////////////////////////////// requant config

    typedef struct packed {
        logic signed [`BIAS_W-1:0] bias;
        logic [`TAIL_W-1:0]        tail; // unsigned
        logic [`RANK_W-1:0]        rank; // 0 means no shift
    } ch_cfg_t;

    typedef ch_cfg_t [`NUM_CH-1:0] quant_cfg_t;

    ////////////////////////////// results

    typedef logic signed [`ACC_W-1:0] acc_t;
    typedef acc_t [`NUM_CH-1:0][`NUM_PIX-1:0] acc_vec_t; // [channel][lane]

    typedef logic signed [`OUT_W-1:0] out_t;
    typedef out_t [`NUM_CH-1:0][`NUM_PIX-1:0] out_vec_t; // [channel][lane]

endpackage

// File: logic/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// array shape
`define NUM_PIX 4 // pixel lanes, at most 8 (one sign bit per lane in binary mode)
`define NUM_CH  2 // output channels per weight word

// datapath widths
`define PIX_W   8  // unsigned pixel
`define ACC_W   24 // signed accumulator
`define BIAS_W  8  // signed bias

// requant scale
`define TAIL_W  16 // unsigned fixed-point tail
`define RANK_W  5  // right shift amount
`define PROD_W  41 // (acc + bias) * tail

// result and control
`define OUT_W   8  // signed result
`define LEN_W   16 // beats per accumulation group

`endif
